// File: logic/micro_defs.svh
// widths, micro-word field positions and micro-ROM entry points of the execution slice
// include wherever a micro-word, an IR or an entry address is handled
`ifndef MICRO_DEFS_SVH
`define MICRO_DEFS_SVH

`define MICRO_ADDR_WIDTH 5            // micro-program counter width
`define MICRO_DATA_WIDTH 38           // full micro-word width
`define MICRO_ROM_DEPTH  14           // words actually programmed in the table
`define IR_SIZE          21           // control bits followed by d, b, a and s

// the IR keeps the low 21 bits of the micro-word layout, so these ranges index both
`define MICRO_S       1:0             // segment field
`define MICRO_A       5:2             // register a, base of memory addresses
`define MICRO_B       9:6             // register b, store data
`define MICRO_D       13:10           // destination register
`define MICRO_FN      16:14           // ALU function, an alu_fn_e
`define MICRO_BIMM    17              // b operand taken from the immediate
`define MICRO_WE      18              // register write on step completion
`define MICRO_MRD     19              // memory read, write data comes from the bus
`define MICRO_MWR     20              // memory write of register b
`define MICRO_CTRL    20:14           // all control bits copied into the IR
`define MICRO_VAR_S   21              // segment comes from the instruction
`define MICRO_VAR_A   23:22           // reg_var_e for a
`define MICRO_VAR_B   25:24           // reg_var_e for b
`define MICRO_VAR_D   27:26           // reg_var_e for d
`define MICRO_VAR_OFF 28              // pass the displacement to the address adder
`define MICRO_VAR_IMM 31:29           // imm_var_e selector
`define MICRO_LAST    32              // final micro-word of the instruction
`define MICRO_NEXT    37:33           // next micro address when not last

`define ENTRY_MOV   5'd0
`define ENTRY_ADDI  5'd1
`define ENTRY_LOAD  5'd2
`define ENTRY_STORE 5'd4
`define ENTRY_XCHG  5'd6
`define ENTRY_SUB   5'd9
`define ENTRY_AND   5'd10
`define ENTRY_XOR   5'd11
`define ENTRY_INC   5'd12
`define ENTRY_DEC   5'd13

`endif

// File: logic/micro_pkg.sv
// encodings shared by the micro-ROM, the data expander and the execute unit
// modules pull these in with a wildcard import in their header
package micro_pkg;

  // ALU operation applied to operand a and operand b
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,                // a plus b, modulo 2^16
    ALU_SUB    = 3'd1,                // a minus b
    ALU_AND    = 3'd2,
    ALU_XOR    = 3'd3,
    ALU_PASS_B = 3'd4                 // b unchanged, used for moves
  } alu_fn_e;

  // immediate choices, same order as the classic expander
  typedef enum logic [2:0] {
    IMM_0    = 3'd0,
    IMM_2    = 3'd1,
    IMM_4    = 3'd2,
    IMM_OFF  = 3'd3,                  // instruction displacement
    IMM_IMM  = 3'd4,                  // instruction immediate
    IMM_FFFF = 3'd5,                  // minus one
    IMM_3    = 3'd6,
    IMM_1    = 3'd7
  } imm_var_e;

  // register operand source, one encoding for the a, b and d fields
  typedef enum logic [1:0] {
    RV_FIXED = 2'd0,                  // number held in the micro-word
    RV_ADDR  = 2'd1,                  // base on a, index on b, unused on d
    RV_DST   = 2'd2,                  // unused on b
    RV_SRC   = 2'd3
  } reg_var_e;

endpackage

// File: logic/micro_rom.sv
// micro-program table for the ten macro-instructions
// purely combinational, the sequencer address selects one micro-word
`timescale 1ns/100ps
`include "micro_defs.svh"

module micro_rom import micro_pkg::*; (
  input  logic [`MICRO_ADDR_WIDTH-1:0] n_micro_i,
  output logic [`MICRO_DATA_WIDTH-1:0] micro_o
);

  // argument order is fn, bimm, we, mrd, mwr, var a/b/d, fixed a/b/d, imm, var seg, off, last, next
  function automatic logic [`MICRO_DATA_WIDTH-1:0] uw(
    input alu_fn_e                     fn,
    input logic                        bimm, we, mrd, mwr,
    input reg_var_e                    va, vb, vd,
    input logic [3:0]                  a, b, d,
    input imm_var_e                    vimm,
    input logic                        vseg, voff, last,
    input logic [`MICRO_ADDR_WIDTH-1:0] nxt
  );
    logic [`MICRO_DATA_WIDTH-1:0] w;
    w                 = '0;               // fixed segment field stays 0
    w[`MICRO_A]       = a;
    w[`MICRO_B]       = b;
    w[`MICRO_D]       = d;
    w[`MICRO_FN]      = fn;
    w[`MICRO_BIMM]    = bimm;
    w[`MICRO_WE]      = we;
    w[`MICRO_MRD]     = mrd;
    w[`MICRO_MWR]     = mwr;
    w[`MICRO_VAR_S]   = vseg;
    w[`MICRO_VAR_A]   = va;
    w[`MICRO_VAR_B]   = vb;
    w[`MICRO_VAR_D]   = vd;
    w[`MICRO_VAR_OFF] = voff;
    w[`MICRO_VAR_IMM] = vimm;
    w[`MICRO_LAST]    = last;
    w[`MICRO_NEXT]    = nxt;
    return w;
  endfunction

  logic [`MICRO_DATA_WIDTH-1:0] halt_word;

  // an unprogrammed address finishes the instruction without touching any state
  assign halt_word = uw(ALU_PASS_B, 1'b0, 1'b0, 1'b0, 1'b0, RV_FIXED, RV_FIXED, RV_FIXED,
                        4'd0, 4'd0, 4'd0, IMM_0, 1'b0, 1'b0, 1'b1, 5'd0);

  always_comb begin
    micro_o = halt_word;
    if (n_micro_i < `MICRO_ROM_DEPTH) begin
      case (n_micro_i)
        `ENTRY_MOV:  micro_o = uw(ALU_PASS_B, 1'b0, 1'b1, 1'b0, 1'b0, RV_FIXED, RV_SRC, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_0, 1'b0, 1'b0, 1'b1, 5'd0);
        `ENTRY_ADDI: micro_o = uw(ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0, RV_DST, RV_FIXED, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_IMM, 1'b0, 1'b0, 1'b1, 5'd0);
        // load forms base plus index in t15, then reads seg:t15+off into dst
        `ENTRY_LOAD: micro_o = uw(ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0, RV_ADDR, RV_ADDR, RV_FIXED,
                                  4'd0, 4'd0, 4'd15, IMM_0, 1'b0, 1'b0, 1'b0, `ENTRY_LOAD + 5'd1);
        `ENTRY_LOAD + 5'd1:
                     micro_o = uw(ALU_PASS_B, 1'b0, 1'b1, 1'b1, 1'b0, RV_FIXED, RV_FIXED, RV_DST,
                                  4'd15, 4'd0, 4'd0, IMM_0, 1'b1, 1'b1, 1'b1, 5'd0);
        // store puts base plus off in t15 and writes src to seg:t15
        `ENTRY_STORE: micro_o = uw(ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0, RV_ADDR, RV_FIXED, RV_FIXED,
                                   4'd0, 4'd0, 4'd15, IMM_OFF, 1'b0, 1'b0, 1'b0,
                                   `ENTRY_STORE + 5'd1);
        `ENTRY_STORE + 5'd1:
                     micro_o = uw(ALU_PASS_B, 1'b0, 1'b0, 1'b0, 1'b1, RV_FIXED, RV_SRC, RV_FIXED,
                                  4'd15, 4'd0, 4'd0, IMM_0, 1'b1, 1'b0, 1'b1, 5'd0);
        // exchange goes through t14, the middle step moves dst as dst plus 0
        `ENTRY_XCHG: micro_o = uw(ALU_PASS_B, 1'b0, 1'b1, 1'b0, 1'b0, RV_FIXED, RV_SRC, RV_FIXED,
                                  4'd0, 4'd0, 4'd14, IMM_0, 1'b0, 1'b0, 1'b0, `ENTRY_XCHG + 5'd1);
        `ENTRY_XCHG + 5'd1:
                     micro_o = uw(ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0, RV_DST, RV_FIXED, RV_SRC,
                                  4'd0, 4'd0, 4'd0, IMM_0, 1'b0, 1'b0, 1'b0, `ENTRY_XCHG + 5'd2);
        `ENTRY_XCHG + 5'd2:
                     micro_o = uw(ALU_PASS_B, 1'b0, 1'b1, 1'b0, 1'b0, RV_FIXED, RV_FIXED, RV_DST,
                                  4'd0, 4'd14, 4'd0, IMM_0, 1'b0, 1'b0, 1'b1, 5'd0);
        `ENTRY_SUB:  micro_o = uw(ALU_SUB, 1'b0, 1'b1, 1'b0, 1'b0, RV_DST, RV_SRC, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_0, 1'b0, 1'b0, 1'b1, 5'd0);
        `ENTRY_AND:  micro_o = uw(ALU_AND, 1'b0, 1'b1, 1'b0, 1'b0, RV_DST, RV_SRC, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_0, 1'b0, 1'b0, 1'b1, 5'd0);
        `ENTRY_XOR:  micro_o = uw(ALU_XOR, 1'b0, 1'b1, 1'b0, 1'b0, RV_DST, RV_SRC, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_0, 1'b0, 1'b0, 1'b1, 5'd0);
        `ENTRY_INC:  micro_o = uw(ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0, RV_DST, RV_FIXED, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_1, 1'b0, 1'b0, 1'b1, 5'd0);
        `ENTRY_DEC:  micro_o = uw(ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0, RV_DST, RV_FIXED, RV_DST,
                                  4'd0, 4'd0, 4'd0, IMM_FFFF, 1'b0, 1'b0, 1'b1, 5'd0);
        default:     micro_o = halt_word;
      endcase
    end
  end

endmodule

// File: logic/micro_data.sv
// micro-word expander, merges the fixed fields with the instruction operands
// gives the IR, the address offset and the immediate of the current step
`timescale 1ns/100ps
`include "micro_defs.svh"

module micro_data import micro_pkg::*; (
  input  logic [`MICRO_DATA_WIDTH-1:0] micro_i,
  input  logic [15:0]                  off_i,
  input  logic [15:0]                  imm_i,
  input  logic [3:0]                   src_i,
  input  logic [3:0]                   dst_i,
  input  logic [3:0]                   base_i,
  input  logic [3:0]                   index_i,
  input  logic [1:0]                   seg_i,
  output logic [`IR_SIZE-1:0]          ir_o,
  output logic [15:0]                  off_o,
  output logic [15:0]                  imm_o
);

  reg_var_e   var_a, var_b, var_d;
  imm_var_e   var_imm;
  logic [3:0] addr_a, addr_b, addr_d;
  logic [1:0] addr_s;

  assign var_a   = reg_var_e'(micro_i[`MICRO_VAR_A]);
  assign var_b   = reg_var_e'(micro_i[`MICRO_VAR_B]);
  assign var_d   = reg_var_e'(micro_i[`MICRO_VAR_D]);
  assign var_imm = imm_var_e'(micro_i[`MICRO_VAR_IMM]);

  always_comb begin
    case (var_a)
      RV_ADDR: addr_a = base_i;               // address base
      RV_DST:  addr_a = dst_i;
      RV_SRC:  addr_a = src_i;
      default: addr_a = micro_i[`MICRO_A];
    endcase
    case (var_b)
      RV_ADDR: addr_b = index_i;              // address index
      RV_SRC:  addr_b = src_i;
      default: addr_b = micro_i[`MICRO_B];    // the dst code has no meaning on b
    endcase
    case (var_d)
      RV_DST:  addr_d = dst_i;
      RV_SRC:  addr_d = src_i;
      default: addr_d = micro_i[`MICRO_D];    // nor does the addr code on d
    endcase
  end

  always_comb begin
    case (var_imm)
      IMM_0:    imm_o = 16'h0000;
      IMM_2:    imm_o = 16'h0002;
      IMM_4:    imm_o = 16'h0004;
      IMM_OFF:  imm_o = off_i;                // lets the ALU add a displacement
      IMM_IMM:  imm_o = imm_i;
      IMM_FFFF: imm_o = 16'hffff;
      IMM_3:    imm_o = 16'h0003;
      default:  imm_o = 16'h0001;
    endcase
  end

  assign off_o  = micro_i[`MICRO_VAR_OFF] ? off_i : 16'h0000;  // zero unless this step asks
  assign addr_s = micro_i[`MICRO_VAR_S] ? seg_i : micro_i[`MICRO_S];

  assign ir_o = {micro_i[`MICRO_CTRL], addr_d, addr_b, addr_a, addr_s};

endmodule

// File: logic/micro_seq.sv
// micro sequencer, takes one macro-instruction at a time and walks its micro-words
// busy_o stays high from the accepted start until done_o pulses
`timescale 1ns/100ps
`include "micro_defs.svh"

module micro_seq (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         start_i,
  input  logic [`MICRO_ADDR_WIDTH-1:0] entry_i,
  input  logic [3:0]                   src_i,
  input  logic [3:0]                   dst_i,
  input  logic [3:0]                   base_i,
  input  logic [3:0]                   index_i,
  input  logic [1:0]                   seg_i,
  input  logic [15:0]                  off_i,
  input  logic [15:0]                  imm_i,
  input  logic                         last_i,
  input  logic [`MICRO_ADDR_WIDTH-1:0] next_i,
  input  logic                         step_done_i,
  output logic [`MICRO_ADDR_WIDTH-1:0] n_micro_o,
  output logic [3:0]                   src_o,
  output logic [3:0]                   dst_o,
  output logic [3:0]                   base_o,
  output logic [3:0]                   index_o,
  output logic [1:0]                   seg_o,
  output logic [15:0]                  off_o,
  output logic [15:0]                  imm_o,
  output logic                         busy_o,
  output logic                         done_o
);

  logic accept;

  // the completion cycle is not an accept slot, so done and a new start never overlap
  assign accept = start_i & ~busy_o & ~done_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_o    <= 1'b0;
      done_o    <= 1'b0;
      n_micro_o <= '0;
    end else begin
      done_o <= 1'b0;                           // single cycle pulse
      if (accept) begin
        busy_o    <= 1'b1;
        n_micro_o <= entry_i;                   // first micro-word of the instruction
      end else if (busy_o && step_done_i) begin
        if (last_i) begin
          busy_o <= 1'b0;                       // falls together with the done pulse
          done_o <= 1'b1;
        end else begin
          n_micro_o <= next_i;                  // link held in the current word
        end
      end
    end
  end

  // operand fields are held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_o   <= src_i;
      dst_o   <= dst_i;
      base_o  <= base_i;
      index_o <= index_i;
      seg_o   <= seg_i;
      off_o   <= off_i;
      imm_o   <= imm_i;
    end
  end

endmodule

// File: logic/micro_exec.sv
// execute unit, runs one expanded IR per step against the 16 entry register file
// memory steps become a Wishbone classic cycle that ends on ack_i
// entries 14 and 15 are scratch registers of the micro-programs
`timescale 1ns/100ps
`include "micro_defs.svh"

module micro_exec import micro_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [`IR_SIZE-1:0] ir_i,
  input  logic [15:0]         off_i,
  input  logic [15:0]         imm_i,
  input  logic                active_i,
  output logic                step_done_o,
  output logic                cyc_o,
  output logic                stb_o,
  output logic                we_o,
  output logic [17:0]         adr_o,
  output logic [15:0]         dat_o,
  input  logic [15:0]         dat_i,
  input  logic                ack_i,
  input  logic [3:0]          rd_sel_i,
  output logic [15:0]         rd_data_o
);

  logic [15:0] regs [16];
  logic [1:0]  addr_s;
  logic [3:0]  addr_a, addr_b, addr_d;
  alu_fn_e     fn;
  logic        b_imm, reg_we, mem_rd, mem_wr, mem_step;
  logic [15:0] op_a, op_b, alu_y, wdata;

  assign addr_s = ir_i[`MICRO_S];
  assign addr_a = ir_i[`MICRO_A];
  assign addr_b = ir_i[`MICRO_B];
  assign addr_d = ir_i[`MICRO_D];
  assign fn     = alu_fn_e'(ir_i[`MICRO_FN]);
  assign b_imm  = ir_i[`MICRO_BIMM];
  assign reg_we = ir_i[`MICRO_WE];
  assign mem_rd = ir_i[`MICRO_MRD];
  assign mem_wr = ir_i[`MICRO_MWR];

  assign mem_step = mem_rd | mem_wr;

  assign op_a = regs[addr_a];
  assign op_b = b_imm ? imm_i : regs[addr_b];   // immediate replaces register b

  always_comb begin
    case (fn)
      ALU_ADD: alu_y = op_a + op_b;             // wraps at 16 bits
      ALU_SUB: alu_y = op_a - op_b;
      ALU_AND: alu_y = op_a & op_b;
      ALU_XOR: alu_y = op_a ^ op_b;
      default: alu_y = op_b;
    endcase
  end

  // bus request lasts as long as the sequencer sits on a memory step
  assign cyc_o = active_i & mem_step;
  assign stb_o = cyc_o;
  assign we_o  = cyc_o & mem_wr;
  assign adr_o = {addr_s, op_a + off_i};        // segment above the word address
  assign dat_o = regs[addr_b];                  // store data always from register b

  // plain steps finish at once, memory steps wait for the slave
  assign step_done_o = active_i & (~mem_step | ack_i);

  assign wdata = mem_rd ? dat_i : alu_y;        // load data is taken in the ack cycle

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'h0000;
      end
    end else if (step_done_o && reg_we) begin
      regs[addr_d] <= wdata;
    end
  end

  assign rd_data_o = regs[rd_sel_i];            // inspection port, no side effects

endmodule

// File: logic/micro_core.sv
// top of the microcoded execution slice
// accepts one macro-instruction per start_i and reports completion on done_o
`timescale 1ns/100ps
`include "micro_defs.svh"

module micro_core (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         start_i,
  input  logic [`MICRO_ADDR_WIDTH-1:0] entry_i,
  input  logic [3:0]                   src_i,
  input  logic [3:0]                   dst_i,
  input  logic [3:0]                   base_i,
  input  logic [3:0]                   index_i,
  input  logic [1:0]                   seg_i,
  input  logic [15:0]                  off_i,
  input  logic [15:0]                  imm_i,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         cyc_o,
  output logic                         stb_o,
  output logic                         we_o,
  output logic [17:0]                  adr_o,
  output logic [15:0]                  dat_o,
  input  logic [15:0]                  dat_i,
  input  logic                         ack_i,
  input  logic [3:0]                   rd_sel_i,
  output logic [15:0]                  rd_data_o
);

  logic [`MICRO_ADDR_WIDTH-1:0] n_micro;
  logic [`MICRO_DATA_WIDTH-1:0] micro;
  logic [`IR_SIZE-1:0]          ir;
  logic [3:0]                   src, dst, base, index;
  logic [1:0]                   seg;
  logic [15:0]                  off, imm, x_off, x_imm;
  logic                         step_done;

  micro_seq u_seq (
    .clk_i, .rst_n_i, .start_i, .entry_i,
    .src_i, .dst_i, .base_i, .index_i, .seg_i, .off_i, .imm_i,
    .last_i (micro[`MICRO_LAST]), .next_i (micro[`MICRO_NEXT]),
    .step_done_i (step_done), .n_micro_o (n_micro),
    .src_o (src), .dst_o (dst), .base_o (base), .index_o (index),
    .seg_o (seg), .off_o (off), .imm_o (imm), .busy_o, .done_o
  );

  micro_rom u_rom (.n_micro_i (n_micro), .micro_o (micro));

  micro_data u_data (
    .micro_i (micro), .off_i (off), .imm_i (imm), .src_i (src), .dst_i (dst),
    .base_i (base), .index_i (index), .seg_i (seg),
    .ir_o (ir), .off_o (x_off), .imm_o (x_imm)
  );

  micro_exec u_exec (
    .clk_i, .rst_n_i, .ir_i (ir), .off_i (x_off), .imm_i (x_imm),
    .active_i (busy_o), .step_done_o (step_done),
    .cyc_o, .stb_o, .we_o, .adr_o, .dat_o, .dat_i, .ack_i,
    .rd_sel_i, .rd_data_o
  );

endmodule

// File: testbench/micro_core_props.sv
// protocol assertions for the execution slice, attached to micro_core with bind
// covers the Wishbone request rules and the start, busy and done handshake
`timescale 1ns/100ps

module micro_core_props (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        start_i,
  input logic        busy_o,
  input logic        done_o,
  input logic        cyc_o,
  input logic        stb_o,
  input logic        we_o,
  input logic [17:0] adr_o,
  input logic        ack_i
);

  // a strobe outside a bus cycle is illegal in Wishbone classic
  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i) stb_o |-> cyc_o)
    else $error("stb_o high without cyc_o");

  // a waiting request keeps its strobe, address and direction
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stb_o && !ack_i) |=> (stb_o && $stable(adr_o) && $stable(we_o)))
    else $error("request changed before ack_i");

  // an accepted start opens a busy period, never a done pulse
  a_start_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (start_i && !busy_o && !done_o) |=> (busy_o && !done_o))
    else $error("done_o seen while a start was accepted");

  a_reset_idle: assert property (@(posedge clk_i) $rose(rst_n_i) |-> (!busy_o && !done_o))
    else $error("busy_o or done_o high after reset");

endmodule

bind micro_core micro_core_props u_props (
  .clk_i, .rst_n_i, .start_i, .busy_o, .done_o,
  .cyc_o, .stb_o, .we_o, .adr_o, .ack_i
);

// File: testbench/micro_core_tb.sv
// testbench of the microcoded execution slice
// random macro-instructions are run against a reference model and a Wishbone memory model
// registers are read back through the inspection port after every done_o
`timescale 1ns/100ps
`include "micro_defs.svh"

module micro_core_tb;

  localparam int N_RANDOM       = 200;          // random single instructions
  localparam int N_PAIRS        = 50;           // store then load of the same word
  localparam int TIMEOUT_CYCLES = 300 * 12;     // 300 instructions, 12 cycles each at most

  logic        clk_i, rst_n_i, start_i, ack_i;
  logic [4:0]  entry_i;
  logic [3:0]  src_i, dst_i, base_i, index_i, rd_sel_i;
  logic [1:0]  seg_i;
  logic [15:0] off_i, imm_i, dat_i, dat_o, rd_data_o;
  logic [17:0] adr_o;
  logic        busy_o, done_o, cyc_o, stb_o, we_o;

  logic [15:0] model_r [14];                    // architectural registers of the model
  logic [15:0] model_mem [4][256];              // memory as the model expects it
  logic [15:0] bus_mem [4][256];                // memory behind the Wishbone slave
  logic [4:0]  ops [10] = '{`ENTRY_MOV, `ENTRY_ADDI, `ENTRY_LOAD, `ENTRY_STORE, `ENTRY_XCHG,
                            `ENTRY_SUB, `ENTRY_AND, `ENTRY_XOR, `ENTRY_INC, `ENTRY_DEC};
  int          errors = 0;
  int          start_cnt = 0;
  int          done_cnt = 0;
  int          cycle_cnt = 0;

  micro_core uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;                  // 4 ns period
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // the read port is combinational, so a short settle is enough
  task automatic read_reg(input logic [3:0] sel, output logic [15:0] val);
    rd_sel_i = sel;
    #0.1;
    val = rd_data_o;
  endtask

  task automatic compare_regs();
    logic [15:0] v;
    for (int i = 0; i < 14; i++) begin
      read_reg(4'(i), v);
      check_value($sformatf("r%0d", i), v, model_r[i]);
    end
  endtask

  // register and memory effects of one macro-instruction
  function automatic void apply_model(input logic [4:0] entry, input logic [3:0] src, dst,
                                      input logic [3:0] base, index, input logic [1:0] seg,
                                      input logic [15:0] off, imm);
    logic [15:0] t;
    case (entry)
      `ENTRY_MOV:  model_r[dst] = model_r[src];
      `ENTRY_ADDI: model_r[dst] = model_r[dst] + imm;
      `ENTRY_LOAD: begin
        t = model_r[base] + model_r[index];     // t15 of the micro-program
        model_r[dst] = model_mem[seg][8'(t + off)];
      end
      `ENTRY_STORE: begin
        t = model_r[base] + off;
        model_mem[seg][8'(t)] = model_r[src];
      end
      `ENTRY_XCHG: begin
        t = model_r[src];                       // t14 of the micro-program
        model_r[src] = model_r[dst];
        model_r[dst] = t;
      end
      `ENTRY_SUB:  model_r[dst] = model_r[dst] - model_r[src];
      `ENTRY_AND:  model_r[dst] = model_r[dst] & model_r[src];
      `ENTRY_XOR:  model_r[dst] = model_r[dst] ^ model_r[src];
      `ENTRY_INC:  model_r[dst] = model_r[dst] + 16'h0001;
      `ENTRY_DEC:  model_r[dst] = model_r[dst] + 16'hffff;
      default:     model_r[dst] = model_r[dst];
    endcase
  endfunction

  // one start pulse, then wait for done_o and check its latency on plain instructions
  task automatic issue(input logic [4:0] entry, input logic [3:0] src, dst, base, index,
                       input logic [1:0] seg, input logic [15:0] off, imm);
    int cycles;
    int steps;
    steps = (entry == `ENTRY_XCHG) ? 3 : 1;
    @(posedge clk_i);
    #1;
    start_i = 1'b1;
    entry_i = entry;
    src_i   = src;
    dst_i   = dst;
    base_i  = base;
    index_i = index;
    seg_i   = seg;
    off_i   = off;
    imm_i   = imm;
    start_cnt++;
    @(posedge clk_i);                           // accepted at this edge
    #1;
    start_i = 1'b0;
    cycles = 0;
    while (done_o !== 1'b1) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    check_value("busy_o", busy_o, 0);           // busy falls together with the done pulse
    if (entry != `ENTRY_LOAD && entry != `ENTRY_STORE) begin
      check_value("done latency", cycles, steps);
    end
  endtask

  task automatic run_one(input logic [4:0] entry, input logic [3:0] src, dst, base, index,
                         input logic [1:0] seg, input logic [15:0] off, imm);
    logic [7:0] st_addr;
    st_addr = 8'(model_r[base] + off);          // word a store will hit
    apply_model(entry, src, dst, base, index, seg, off, imm);
    issue(entry, src, dst, base, index, seg, off, imm);
    compare_regs();
    if (entry == `ENTRY_STORE) begin
      check_value("store mem", bus_mem[seg][st_addr], model_mem[seg][st_addr]);
    end
  endtask

  // Wishbone slave, acks after 0 to 3 wait cycles
  initial begin
    int wait_n;
    ack_i = 1'b0;
    dat_i = 16'h0000;
    forever begin
      @(posedge clk_i);
      #1;
      if (cyc_o && stb_o) begin
        wait_n = $urandom_range(3, 0);
        repeat (wait_n) begin
          @(posedge clk_i);
          #1;
        end
        if (we_o) begin
          bus_mem[adr_o[17:16]][adr_o[7:0]] = dat_o;
        end else begin
          dat_i = bus_mem[adr_o[17:16]][adr_o[7:0]];
        end
        ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        ack_i = 1'b0;
      end
    end
  end

  always @(negedge clk_i) begin
    if (done_o) begin
      done_cnt++;                               // mid-cycle sample, one count per pulse
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    logic [4:0]  op;
    logic [3:0]  src, dst, base, index;
    logic [1:0]  seg;
    logic [15:0] off, imm, st_full, stored, v;
    void'($urandom(80));
    rst_n_i  = 1'b0;
    start_i  = 1'b0;
    entry_i  = 5'd0;
    src_i    = 4'd0;
    dst_i    = 4'd0;
    base_i   = 4'd0;
    index_i  = 4'd0;
    seg_i    = 2'd0;
    off_i    = 16'h0000;
    imm_i    = 16'h0000;
    rd_sel_i = 4'd0;
    for (int s = 0; s < 4; s++) begin
      for (int w = 0; w < 256; w++) begin
        model_mem[s][w] = 16'((s * 256 + w) * 40503) ^ 16'h6d3c;   // differs for every word
        bus_mem[s][w]   = model_mem[s][w];
      end
    end
    for (int i = 0; i < 14; i++) begin
      model_r[i] = 16'h0000;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_value("busy_o", busy_o, 0);
    check_value("done_o", done_o, 0);
    check_value("cyc_o", cyc_o, 0);
    check_value("stb_o", stb_o, 0);
    check_value("we_o", we_o, 0);
    for (int i = 0; i < 16; i++) begin
      read_reg(4'(i), v);
      check_value($sformatf("reset r%0d", i), v, 0);
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      op    = ops[$urandom_range(9, 0)];
      src   = 4'($urandom_range(13, 0));
      dst   = 4'($urandom_range(13, 0));
      base  = 4'($urandom_range(13, 0));
      index = 4'($urandom_range(13, 0));
      seg   = 2'($urandom);
      off   = 16'($urandom);
      imm   = 16'($urandom);
      run_one(op, src, dst, base, index, seg, off, imm);
    end
    // the load offset is chosen so that it reads back the word just stored
    for (int k = 0; k < N_PAIRS; k++) begin
      src     = 4'($urandom_range(13, 0));
      base    = 4'($urandom_range(13, 0));
      seg     = 2'($urandom);
      off     = 16'($urandom);
      st_full = model_r[base] + off;
      stored  = model_r[src];
      run_one(`ENTRY_STORE, src, 4'd0, base, 4'd0, seg, off, 16'h0000);
      dst   = 4'($urandom_range(13, 0));
      base  = 4'($urandom_range(13, 0));
      index = 4'($urandom_range(13, 0));
      off   = st_full - model_r[base] - model_r[index];
      run_one(`ENTRY_LOAD, 4'd0, dst, base, index, seg, off, 16'h0000);
      read_reg(dst, v);
      check_value("load data", v, stored);
    end
    @(posedge clk_i);                           // lets the last done pulse be counted
    #1;
    check_value("done count", done_cnt, start_cnt);
    $display("errors: %0d, starts: %0d, done pulses: %0d", errors, start_cnt, done_cnt);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/micro_pkg.sv
logic/micro_rom.sv
logic/micro_data.sv
logic/micro_seq.sv
logic/micro_exec.sv
logic/micro_core.sv
testbench/micro_core_props.sv
testbench/micro_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator and run, the result is taken from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module micro_core_tb -f src.f -o micro_core_sim \
  && out="$(./obj_dir/micro_core_sim)" \
  && echo "$out" \
  && echo "$out" | grep -q "^TESTS PASSED$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
